// ==== mips_mmu.f ====
rtl/mmu_pkg.sv
rtl/cp0_tlb_regs.sv
rtl/tlb.sv
rtl/addr_translate.sv
rtl/mmu_top.sv
bench/tb_mmu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu \
    -Mdir obj_dir -f mips_mmu.f || exit 1
out=$(./obj_dir/Vtb_mmu)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '>>> PASS' && exit 0 || exit 1

// ==== bench/tb_mmu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mmu;

    localparam int WAIT_LIMIT = 100;

    logic                clk;
    logic                rst_n;
    mmu_pkg::axil_req_t  axil_req;
    mmu_pkg::axil_rsp_t  axil_rsp;
    mmu_pkg::xlate_req_t inst_req;
    mmu_pkg::xlate_req_t data_req;
    mmu_pkg::xlate_rsp_t inst_rsp;
    mmu_pkg::xlate_rsp_t data_rsp;
    int                  errors;
    int                  tests;
    int                  failed;

    // slot 2 holds a private entry, slot 5 a global one
    logic [18:0] vpn2_a;
    logic [7:0]  asid_a;
    logic [31:0] lo0_a;
    logic [31:0] lo1_a;
    logic [31:0] hi_g;
    logic [31:0] lo_g;

    mmu_top dut0 (
        .clk, .rst_n,
        .s_axil_req(axil_req), .s_axil_rsp(axil_rsp),
        .inst_req, .inst_rsp, .data_req, .data_rsp
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s: got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(input string what, input mmu_pkg::xlate_rsp_t got,
                             input mmu_pkg::xlate_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s: got v=%0b pa=%08h unc=%0b ex=%0b refill=%0b code=%0d",
                     $time, what, got.valid, got.paddr, got.uncached, got.ex, got.refill,
                     got.exccode);
            $display("    expected v=%0b pa=%08h unc=%0b ex=%0b refill=%0b code=%0d",
                     exp.valid, exp.paddr, exp.uncached, exp.ex, exp.refill, exp.exccode);
        end
    endtask

    function automatic mmu_pkg::xlate_rsp_t ok_rsp(input logic [31:0] pa, input logic unc);
        mmu_pkg::xlate_rsp_t r;
        r          = '0;
        r.valid    = 1'b1;
        r.paddr    = pa;
        r.uncached = unc;
        return r;
    endfunction

    // faults carry no address
    function automatic mmu_pkg::xlate_rsp_t fault_rsp(input logic refill, input logic [4:0] code);
        mmu_pkg::xlate_rsp_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.ex      = 1'b1;
        r.refill  = refill;
        r.exccode = code;
        return r;
    endfunction

    function automatic mmu_pkg::xlate_req_t make_req(input logic [31:0] va, input logic store);
        mmu_pkg::xlate_req_t r;
        r.valid    = 1'b1;
        r.vaddr    = va;
        r.is_store = store;
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one request per port, responses due exactly one cycle later
    task automatic xlate_pair(input string what, input logic [31:0] iva, input logic [31:0] dva,
                              input logic dstore, input mmu_pkg::xlate_rsp_t iexp,
                              input mmu_pkg::xlate_rsp_t dexp);
        // fetch port gets the store flag too, a fetch never stores
        inst_req = make_req(iva, dstore);
        data_req = make_req(dva, dstore);
        step();
        check_rsp({what, ", inst port"}, inst_rsp, iexp);
        check_rsp({what, ", data port"}, data_rsp, dexp);
    endtask

    task automatic idle();
        inst_req = '0;
        data_req = '0;
        step();
        check_word("valid after idle", {30'b0, inst_rsp.valid, data_rsp.valid}, 32'd0);
    endtask

    task automatic axil_write(input logic [5:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        n = 0;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            if (n == WAIT_LIMIT) stop_on_timeout("the AW/W handshake");
            n++;
            @(negedge clk);
        end
        step();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            if (n == WAIT_LIMIT) stop_on_timeout("the B response");
            n++;
            @(negedge clk);
        end
        check_word("bresp", {30'b0, axil_rsp.bresp}, 32'd0);
        step();
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
        int n;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            if (n == WAIT_LIMIT) stop_on_timeout("the AR handshake");
            n++;
            @(negedge clk);
        end
        step();
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            if (n == WAIT_LIMIT) stop_on_timeout("the R response");
            n++;
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        check_word("rresp", {30'b0, axil_rsp.rresp}, 32'd0);
        step();
        axil_req.rready = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [5:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        axil_read(addr, rd);
        check_word(what, rd, exp);
    endtask

    task automatic tlb_cmd(input logic [1:0] cmd);
        axil_write(mmu_pkg::REG_TLBCMD, {30'b0, cmd}, 4'h1);
    endtask

    task automatic write_entry(input logic [2:0] idx, input logic [31:0] hi,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        axil_write(mmu_pkg::REG_INDEX, {29'b0, idx}, 4'hF);
        axil_write(mmu_pkg::REG_ENTRYLO0, lo0, 4'hF);
        axil_write(mmu_pkg::REG_ENTRYLO1, lo1, 4'hF);
        axil_write(mmu_pkg::REG_ENTRYHI, hi, 4'hF);
        tlb_cmd(mmu_pkg::CMD_TLBWI);
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_word("rsp valid", {30'b0, inst_rsp.valid, data_rsp.valid}, 32'd0);
        check_word("bvalid/rvalid", {30'b0, axil_rsp.bvalid, axil_rsp.rvalid}, 32'd0);
        read_check("Index", mmu_pkg::REG_INDEX, 32'd0);
        read_check("EntryLo0", mmu_pkg::REG_ENTRYLO0, 32'd0);
        read_check("EntryLo1", mmu_pkg::REG_ENTRYLO1, 32'd0);
        read_check("EntryHi", mmu_pkg::REG_ENTRYHI, 32'd0);
        read_check("Config", mmu_pkg::REG_CONFIG, 32'd3);
        read_check("command offset", mmu_pkg::REG_TLBCMD, 32'd0);
        finish_test("reset state", start);
    endtask

    task automatic test_unmapped();
        int start;
        logic [28:0] off0;
        logic [28:0] off1;
        start = errors;
        off0 = 29'($urandom);
        off1 = 29'($urandom);
        xlate_pair("kseg1 / kseg0", {3'b101, off1}, {3'b100, off0}, 1'b0,
                   ok_rsp({3'b0, off1}, 1'b1), ok_rsp({3'b0, off0}, 1'b0));
        // back to back, segments swapped
        xlate_pair("kseg0 / kseg1", {3'b100, off0}, {3'b101, off1}, 1'b1,
                   ok_rsp({3'b0, off0}, 1'b0), ok_rsp({3'b0, off1}, 1'b1));
        idle();
        axil_write(mmu_pkg::REG_CONFIG, 32'd2, 4'hF);
        xlate_pair("kseg0 with K0 uncached", {3'b100, off1}, {3'b100, off0}, 1'b0,
                   ok_rsp({3'b0, off1}, 1'b1), ok_rsp({3'b0, off0}, 1'b1));
        idle();
        axil_write(mmu_pkg::REG_CONFIG, 32'd3, 4'hF);
        finish_test("unmapped segments", start);
    endtask

    task automatic test_tlbwi();
        int start;
        logic [11:0] off;
        logic [18:0] vpn2_g;
        start = errors;
        off    = 12'($urandom);
        vpn2_a = {3'b000, 16'($urandom)};
        asid_a = 8'($urandom);
        // G only on the even page, so the entry is not global
        lo0_a  = {6'b0, 20'($urandom), 3'd3, 1'b1, 1'b1, 1'b1};
        lo1_a  = {6'b0, 20'($urandom), mmu_pkg::CACHE_UNCACHED, 1'b1, 1'b1, 1'b0};
        write_entry(3'd2, {vpn2_a, 5'b0, asid_a}, lo0_a, lo1_a);
        xlate_pair("even fetch, odd load", {vpn2_a, 1'b0, off}, {vpn2_a, 1'b1, off}, 1'b0,
                   ok_rsp({lo0_a[25:6], off}, 1'b0), ok_rsp({lo1_a[25:6], off}, 1'b1));
        xlate_pair("odd fetch, even store", {vpn2_a, 1'b1, off}, {vpn2_a, 1'b0, off}, 1'b1,
                   ok_rsp({lo1_a[25:6], off}, 1'b1), ok_rsp({lo0_a[25:6], off}, 1'b0));
        idle();
        // private entry under another ASID
        axil_write(mmu_pkg::REG_ENTRYHI, {vpn2_a, 5'b0, asid_a ^ 8'h5A}, 4'hF);
        xlate_pair("other ASID", {vpn2_a, 1'b0, off}, {vpn2_a, 1'b1, off}, 1'b0,
                   fault_rsp(1'b1, mmu_pkg::EXC_TLBL), fault_rsp(1'b1, mmu_pkg::EXC_TLBL));
        idle();
        // global entry in kseg2
        vpn2_g = {3'b110, 16'($urandom)};
        hi_g   = {vpn2_g, 5'b0, 8'($urandom)};
        lo_g   = {6'b0, 20'($urandom), 3'd3, 1'b1, 1'b1, 1'b1};
        write_entry(3'd5, hi_g, lo_g, lo_g);
        axil_write(mmu_pkg::REG_ENTRYHI, {24'b0, hi_g[7:0] ^ 8'hC3}, 4'hF);
        xlate_pair("global entry", {vpn2_g, 1'b1, off}, {vpn2_g, 1'b0, off}, 1'b1,
                   ok_rsp({lo_g[25:6], off}, 1'b0), ok_rsp({lo_g[25:6], off}, 1'b0));
        idle();
        finish_test("TLBWI and mapped translation", start);
    endtask

    task automatic test_exceptions();
        int start;
        logic [11:0] off;
        logic [18:0] vpn2_m;
        logic [18:0] vpn2_i;
        logic [31:0] lo1_i;
        start = errors;
        off    = 12'($urandom);
        vpn2_m = {3'b111, 16'($urandom)};
        xlate_pair("miss", {vpn2_m, 1'b0, off}, {vpn2_m, 1'b1, off}, 1'b1,
                   fault_rsp(1'b1, mmu_pkg::EXC_TLBL), fault_rsp(1'b1, mmu_pkg::EXC_TLBS));
        idle();
        // even page invalid, odd page valid but clean
        vpn2_i = {3'b001, 16'($urandom)};
        lo1_i  = {6'b0, 20'($urandom), 3'd3, 1'b0, 1'b1, 1'b0};
        write_entry(3'd4, {vpn2_i, 5'b0, asid_a}, {6'b0, 20'($urandom), 3'd3, 1'b1, 1'b0, 1'b0},
                    lo1_i);
        xlate_pair("invalid page", {vpn2_i, 1'b0, off}, {vpn2_i, 1'b0, off}, 1'b1,
                   fault_rsp(1'b0, mmu_pkg::EXC_TLBL), fault_rsp(1'b0, mmu_pkg::EXC_TLBS));
        xlate_pair("clean page", {vpn2_i, 1'b1, off}, {vpn2_i, 1'b1, off}, 1'b1,
                   ok_rsp({lo1_i[25:6], off}, 1'b0), fault_rsp(1'b0, mmu_pkg::EXC_MOD));
        idle();
        finish_test("exceptions", start);
    endtask

    task automatic test_probe_read();
        int start;
        start = errors;
        axil_write(mmu_pkg::REG_ENTRYHI, {vpn2_a, 5'b0, asid_a}, 4'hF);
        tlb_cmd(mmu_pkg::CMD_TLBP);
        read_check("Index after probe hit", mmu_pkg::REG_INDEX, 32'h0000_0002);
        axil_write(mmu_pkg::REG_ENTRYHI, {3'b111, ~vpn2_a[15:0], 5'b0, asid_a}, 4'hF);
        tlb_cmd(mmu_pkg::CMD_TLBP);
        read_check("Index after probe miss", mmu_pkg::REG_INDEX, 32'h8000_0002);
        axil_write(mmu_pkg::REG_INDEX, 32'd5, 4'hF);
        tlb_cmd(mmu_pkg::CMD_TLBR);
        read_check("EntryHi of slot 5", mmu_pkg::REG_ENTRYHI, hi_g);
        read_check("EntryLo0 of slot 5", mmu_pkg::REG_ENTRYLO0, lo_g);
        read_check("EntryLo1 of slot 5", mmu_pkg::REG_ENTRYLO1, lo_g);
        axil_write(mmu_pkg::REG_INDEX, 32'd2, 4'hF);
        tlb_cmd(mmu_pkg::CMD_TLBR);
        read_check("EntryHi of slot 2", mmu_pkg::REG_ENTRYHI, {vpn2_a, 5'b0, asid_a});
        // entry G is the AND of both written G bits, so zero here
        read_check("EntryLo0 of slot 2", mmu_pkg::REG_ENTRYLO0, {lo0_a[31:1], 1'b0});
        read_check("EntryLo1 of slot 2", mmu_pkg::REG_ENTRYLO1, lo1_a);
        finish_test("TLBP and TLBR", start);
    endtask

    initial begin
        void'($urandom(38));
        errors   = 0;
        tests    = 0;
        failed   = 0;
        rst_n    = 1'b0;
        axil_req = '0;
        inst_req = '0;
        data_req = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_unmapped();
        test_tlbwi();
        test_exceptions();
        test_probe_read();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/mmu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::axil_req_t  s_axil_req,
    output mmu_pkg::axil_rsp_t  s_axil_rsp,
    input  mmu_pkg::xlate_req_t inst_req,
    output mmu_pkg::xlate_rsp_t inst_rsp,
    input  mmu_pkg::xlate_req_t data_req,
    output mmu_pkg::xlate_rsp_t data_rsp
);

    logic                          tlbw_we;
    logic [mmu_pkg::TLB_IDX_W-1:0] tlbw_index;
    mmu_pkg::tlb_entry_t           tlbw_entry;
    logic [mmu_pkg::TLB_IDX_W-1:0] tlbr_index;
    mmu_pkg::tlb_entry_t           tlbr_entry;
    logic [18:0]                   probe_vpn2;
    logic [7:0]                    probe_asid;
    logic                          probe_hit;
    logic [mmu_pkg::TLB_IDX_W-1:0] probe_index;
    logic [7:0]                    asid;
    logic [2:0]                    k0;
    logic [1:0][18:0]              lookup_vpn2;
    mmu_pkg::tlb_hit_t [1:0]       lookup_res;
    mmu_pkg::xlate_req_t           inst_req_ld;

    // fetches never store
    assign inst_req_ld = '{valid: inst_req.valid, vaddr: inst_req.vaddr, is_store: 1'b0};

    cp0_tlb_regs u_cp0_tlb_regs (
        .clk, .rst_n,
        .s_axil_req, .s_axil_rsp,
        .tlbw_we, .tlbw_index, .tlbw_entry,
        .tlbr_index, .tlbr_entry,
        .probe_vpn2, .probe_asid, .probe_hit, .probe_index,
        .asid, .k0
    );

    tlb u_tlb (
        .clk, .rst_n,
        .lookup_vpn2, .lookup_asid(asid), .lookup_res,
        .tlbw_we, .tlbw_index, .tlbw_entry,
        .tlbr_index, .tlbr_entry,
        .probe_vpn2, .probe_asid, .probe_hit, .probe_index
    );

    addr_translate u_inst_xlate (
        .clk, .rst_n,
        .req(inst_req_ld), .k0,
        .lookup_vpn2(lookup_vpn2[0]), .tlb_res(lookup_res[0]),
        .rsp(inst_rsp)
    );

    addr_translate u_data_xlate (
        .clk, .rst_n,
        .req(data_req), .k0,
        .lookup_vpn2(lookup_vpn2[1]), .tlb_res(lookup_res[1]),
        .rsp(data_rsp)
    );

endmodule

`default_nettype wire

// ==== rtl/addr_translate.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_translate (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::xlate_req_t req,
    input  logic [2:0]          k0,
    output logic [18:0]         lookup_vpn2,
    input  mmu_pkg::tlb_hit_t   tlb_res,
    output mmu_pkg::xlate_rsp_t rsp
);

    mmu_pkg::tlb_page_t  sel_page;
    mmu_pkg::xlate_rsp_t rsp_d;
    logic [4:0]          miss_code;

    assign lookup_vpn2 = req.vaddr.page.vpn2;

    // odd bit picks the page of the pair
    assign sel_page  = tlb_res.entry.page[req.vaddr.page.odd];
    assign miss_code = req.is_store ? mmu_pkg::EXC_TLBS : mmu_pkg::EXC_TLBL;

    always_comb begin
        rsp_d       = '0;
        rsp_d.valid = req.valid;
        case (req.vaddr.segment.seg)
            mmu_pkg::SEG_KSEG0: begin
                rsp_d.paddr    = {3'b0, req.vaddr.segment.low};
                rsp_d.uncached = (k0 == mmu_pkg::CACHE_UNCACHED);
            end
            mmu_pkg::SEG_KSEG1: begin
                rsp_d.paddr    = {3'b0, req.vaddr.segment.low};
                rsp_d.uncached = 1'b1;
            end
            default: begin
                // kuseg, kseg2 and kseg3 go through the TLB
                if (!tlb_res.hit) begin
                    rsp_d.ex      = 1'b1;
                    rsp_d.refill  = 1'b1;
                    rsp_d.exccode = miss_code;
                end else if (!sel_page.v) begin
                    rsp_d.ex      = 1'b1;
                    rsp_d.exccode = miss_code;
                end else if (req.is_store && !sel_page.d) begin
                    rsp_d.ex      = 1'b1;
                    rsp_d.exccode = mmu_pkg::EXC_MOD;
                end else begin
                    rsp_d.paddr    = {sel_page.pfn, req.vaddr.page.offset};
                    rsp_d.uncached = (sel_page.c == mmu_pkg::CACHE_UNCACHED);
                end
            end
        endcase
    end

    // result register, one cycle per request
    always_ff @(posedge clk) begin
        rsp <= rsp_d;
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [1:0][18:0]              lookup_vpn2,
    input  logic [7:0]                    lookup_asid,
    output mmu_pkg::tlb_hit_t [1:0]       lookup_res,
    input  logic                          tlbw_we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] tlbw_index,
    input  mmu_pkg::tlb_entry_t           tlbw_entry,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] tlbr_index,
    output mmu_pkg::tlb_entry_t           tlbr_entry,
    input  logic [18:0]                   probe_vpn2,
    input  logic [7:0]                    probe_asid,
    output logic                          probe_hit,
    output logic [mmu_pkg::TLB_IDX_W-1:0] probe_index
);

    mmu_pkg::tlb_entry_t entries [mmu_pkg::TLB_ENTRIES];

    // a slot never written since reset matches nothing
    logic [mmu_pkg::TLB_ENTRIES-1:0]      filled;
    logic [1:0][mmu_pkg::TLB_ENTRIES-1:0] lookup_match;
    logic [mmu_pkg::TLB_ENTRIES-1:0]      probe_match;

    function automatic logic entry_match(input mmu_pkg::tlb_entry_t e,
                                         input logic [18:0]         vpn2,
                                         input logic [7:0]          asid_in);
        return (e.vpn2 == vpn2) && (e.g || (e.asid == asid_in));
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            filled <= '0;
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (tlbw_we) begin
            filled[tlbw_index]  <= 1'b1;
            entries[tlbw_index] <= tlbw_entry;
        end
    end

    assign tlbr_entry = entries[tlbr_index];

    // two translation lookups, both under the current ASID
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            lookup_res[p] = '0;
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                lookup_match[p][i] = filled[i]
                                     && entry_match(entries[i], lookup_vpn2[p], lookup_asid);
                if (lookup_match[p][i]) begin
                    lookup_res[p].hit   = 1'b1;
                    lookup_res[p].entry = entries[i];
                end
            end
        end
    end

    // probe with EntryHi, lowest slot wins
    always_comb begin
        probe_hit   = 1'b0;
        probe_index = '0;
        for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            probe_match[i] = filled[i] && entry_match(entries[i], probe_vpn2, probe_asid);
            if (probe_match[i]) begin
                probe_hit   = 1'b1;
                probe_index = i[mmu_pkg::TLB_IDX_W-1:0];
            end
        end
    end

    // software must never program overlapping entries
    a_single_match: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lookup_match[0]) && $onehot0(lookup_match[1]) && $onehot0(probe_match));

endmodule

`default_nettype wire

// ==== rtl/cp0_tlb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module cp0_tlb_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mmu_pkg::axil_req_t            s_axil_req,
    output mmu_pkg::axil_rsp_t            s_axil_rsp,
    output logic                          tlbw_we,
    output logic [mmu_pkg::TLB_IDX_W-1:0] tlbw_index,
    output mmu_pkg::tlb_entry_t           tlbw_entry,
    output logic [mmu_pkg::TLB_IDX_W-1:0] tlbr_index,
    input  mmu_pkg::tlb_entry_t           tlbr_entry,
    output logic [18:0]                   probe_vpn2,
    output logic [7:0]                    probe_asid,
    input  logic                          probe_hit,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] probe_index,
    output logic [7:0]                    asid,
    output logic [2:0]                    k0
);

    logic                          index_p;
    logic [mmu_pkg::TLB_IDX_W-1:0] index_idx;
    logic [31:0]                   entrylo0;
    logic [31:0]                   entrylo1;
    logic [31:0]                   entryhi;
    logic [2:0]                    k0_q;

    logic        wr_hs;
    logic        rd_hs;
    logic        cmd_wr;
    logic [1:0]  cmd;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_d;
    logic [31:0] rdata_q;

    function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic mmu_pkg::tlb_page_t lo_to_page(input logic [31:0] lo);
        mmu_pkg::tlb_page_t pg;
        pg.pfn = lo[25:6];
        pg.c   = lo[5:3];
        pg.d   = lo[2];
        pg.v   = lo[1];
        return pg;
    endfunction

    function automatic logic [31:0] page_to_lo(input mmu_pkg::tlb_page_t pg, input logic g);
        return {6'b0, pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    // AW and W are only taken together, one write in flight
    assign wr_hs  = s_axil_req.awvalid && s_axil_req.wvalid && !bvalid_q;
    assign rd_hs  = s_axil_req.arvalid && !rvalid_q;
    assign cmd_wr = wr_hs && (s_axil_req.awaddr == mmu_pkg::REG_TLBCMD) && s_axil_req.wstrb[0];
    assign cmd    = s_axil_req.wdata[1:0];

    assign tlbw_we         = cmd_wr && (cmd == mmu_pkg::CMD_TLBWI);
    assign tlbw_index      = index_idx;
    assign tlbr_index      = index_idx;
    assign tlbw_entry.vpn2 = entryhi[31:13];
    assign tlbw_entry.asid = entryhi[7:0];
    assign tlbw_entry.g    = entrylo0[0] & entrylo1[0];
    assign tlbw_entry.page = {lo_to_page(entrylo1), lo_to_page(entrylo0)};

    assign probe_vpn2 = entryhi[31:13];
    assign probe_asid = entryhi[7:0];
    assign asid       = entryhi[7:0];
    assign k0         = k0_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_p   <= 1'b0;
            index_idx <= '0;
            entrylo0  <= '0;
            entrylo1  <= '0;
            entryhi   <= '0;
            k0_q      <= mmu_pkg::K0_RESET;
        end else if (cmd_wr) begin
            case (cmd)
                mmu_pkg::CMD_TLBR: begin
                    entryhi  <= {tlbr_entry.vpn2, 5'b0, tlbr_entry.asid};
                    entrylo0 <= page_to_lo(tlbr_entry.page[0], tlbr_entry.g);
                    entrylo1 <= page_to_lo(tlbr_entry.page[1], tlbr_entry.g);
                end
                mmu_pkg::CMD_TLBP: begin
                    // on a miss only P changes, the old index stays
                    index_p <= !probe_hit;
                    if (probe_hit) begin
                        index_idx <= probe_index;
                    end
                end
                default: ;
            endcase
        end else if (wr_hs) begin
            case (s_axil_req.awaddr)
                mmu_pkg::REG_INDEX: begin
                    if (s_axil_req.wstrb[0]) begin
                        index_idx <= s_axil_req.wdata[mmu_pkg::TLB_IDX_W-1:0];
                    end
                end
                mmu_pkg::REG_ENTRYLO0: begin
                    entrylo0 <= strb_merge(entrylo0, s_axil_req.wdata, s_axil_req.wstrb)
                                & mmu_pkg::ENTRYLO_MASK;
                end
                mmu_pkg::REG_ENTRYLO1: begin
                    entrylo1 <= strb_merge(entrylo1, s_axil_req.wdata, s_axil_req.wstrb)
                                & mmu_pkg::ENTRYLO_MASK;
                end
                mmu_pkg::REG_ENTRYHI: begin
                    entryhi <= strb_merge(entryhi, s_axil_req.wdata, s_axil_req.wstrb)
                               & mmu_pkg::ENTRYHI_MASK;
                end
                mmu_pkg::REG_CONFIG: begin
                    if (s_axil_req.wstrb[0]) begin
                        k0_q <= s_axil_req.wdata[2:0];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (s_axil_req.araddr)
            mmu_pkg::REG_INDEX:    rdata_d = {index_p, 28'b0, index_idx};
            mmu_pkg::REG_ENTRYLO0: rdata_d = entrylo0;
            mmu_pkg::REG_ENTRYLO1: rdata_d = entrylo1;
            mmu_pkg::REG_ENTRYHI:  rdata_d = entryhi;
            mmu_pkg::REG_CONFIG:   rdata_d = {29'b0, k0_q};
            default:               rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (s_axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (s_axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rdata_d;
        end
    end

    assign s_axil_rsp.awready = wr_hs;
    assign s_axil_rsp.wready  = wr_hs;
    assign s_axil_rsp.bvalid  = bvalid_q;
    assign s_axil_rsp.bresp   = 2'b00;
    assign s_axil_rsp.arready = !rvalid_q;
    assign s_axil_rsp.rvalid  = rvalid_q;
    assign s_axil_rsp.rdata   = rdata_q;
    assign s_axil_rsp.rresp   = 2'b00;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_q && !s_axil_req.bready |=> bvalid_q);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_q && !s_axil_req.rready |=> rvalid_q);

    // a TLB write belongs to exactly one write handshake and its B response
    a_tlbw_in_hs: assert property (@(posedge clk) disable iff (!rst_n)
        tlbw_we |-> s_axil_req.awvalid && s_axil_req.wvalid && !bvalid_q
                    ##1 bvalid_q && !tlbw_we);

endmodule

`default_nettype wire

// ==== rtl/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;

    // word offsets on the AXI4-Lite register port
    localparam logic [5:0] REG_INDEX    = 6'h00;
    localparam logic [5:0] REG_ENTRYLO0 = 6'h04;
    localparam logic [5:0] REG_ENTRYLO1 = 6'h08;
    localparam logic [5:0] REG_ENTRYHI  = 6'h0C;
    localparam logic [5:0] REG_CONFIG   = 6'h10;
    localparam logic [5:0] REG_TLBCMD   = 6'h14;

    localparam logic [1:0] CMD_TLBR  = 2'd1;
    localparam logic [1:0] CMD_TLBWI = 2'd2;
    localparam logic [1:0] CMD_TLBP  = 2'd3;

    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;

    localparam logic [2:0] CACHE_UNCACHED = 3'd2;
    localparam logic [2:0] K0_RESET       = 3'd3;

    // unmapped segments, top three address bits
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // writable bits of the CP0 registers
    localparam logic [31:0] ENTRYLO_MASK = 32'h03FF_FFFF;
    localparam logic [31:0] ENTRYHI_MASK = 32'hFFFF_E0FF;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] offset;
    } virt_page_t;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] low;
    } virt_seg_t;

    typedef union packed {
        virt_page_t page;
        virt_seg_t  segment;
    } virt_u;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    // page[0] is the even page, page[1] the odd one
    typedef struct packed {
        logic [18:0]     vpn2;
        logic [7:0]      asid;
        logic            g;
        tlb_page_t [1:0] page;
    } tlb_entry_t;

    typedef struct packed {
        logic  valid;
        virt_u vaddr;
        logic  is_store;
    } xlate_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        uncached;
        logic        ex;
        logic        refill;
        logic [4:0]  exccode;
    } xlate_rsp_t;

    typedef struct packed {
        logic       hit;
        tlb_entry_t entry;
    } tlb_hit_t;

    typedef struct packed {
        logic        awvalid;
        logic [5:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [5:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire
